// File: files.f
logic/isaPkg.sv
logic/corePkg.sv
logic/instructionDecoder.sv
logic/registerFile.sv
logic/shiftAlu.sv
logic/executeSequencer.sv
logic/decodeExecuteTop.sv
testbench/decodeExecuteTb.sv

// File: logic/corePkg.sv
package corePkg;

  localparam int dataWidth = 16;
  localparam int regCount = 16;

  typedef logic [dataWidth-1:0] dataT;

  // NZCV, N on top
  typedef logic [3:0] flagsT;

  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  typedef enum logic [2:0] {
    idle,           // Waiting for instrReq
    instrAckHigh,   // Instruction latched, waiting for instrReq low
    execute,        // Single commit cycle
    retireHigh,     // Record offered, waiting for retireAck
    retireRelease   // Waiting for retireAck low
  } seqStateT;

endpackage

// File: logic/decodeExecuteTop.sv
`timescale 1ns/1ns

module decodeExecuteTop (
  input  logic            clk,
  input  logic            reset,
  input  logic            instrReq,
  input  isaPkg::instrT   instr,
  output logic            instrAck,
  input  logic            isBios,
  input  logic            isKernel,
  output logic            retireReq,
  output isaPkg::instrIdT retireId,
  output logic            retireWrite,
  output isaPkg::regIdxT  retireReg,
  output corePkg::dataT   retireData,
  output corePkg::flagsT  retireFlags,
  input  logic            retireAck
);

  isaPkg::instrT decodeInstr;
  isaPkg::instrIdT decId;
  isaPkg::regIdxT decRegD;
  isaPkg::regIdxT decRegA;
  isaPkg::regIdxT decRegB;
  isaPkg::offsetT decOffset;
  corePkg::dataT rfDataA;
  corePkg::dataT rfDataB;
  corePkg::dataT aluResult;
  corePkg::flagsT aluNextFlags;
  logic aluWriteEn;
  logic commit;
  logic rfWriteEn;

  assign rfWriteEn = aluWriteEn & commit;

  executeSequencer u_seq (
    .clk         (clk),
    .reset       (reset),
    .instrReq    (instrReq),
    .instr       (instr),
    .retireAck   (retireAck),
    .aluId       (decId),
    .aluWrite    (aluWriteEn),
    .aluDest     (decRegD),
    .aluResult   (aluResult),
    .aluFlags    (aluNextFlags),
    .instrAck    (instrAck),
    .retireReq   (retireReq),
    .decodeInstr (decodeInstr),
    .commit      (commit),
    .retireId    (retireId),
    .retireWrite (retireWrite),
    .retireReg   (retireReg),
    .retireData  (retireData),
    .retireFlags (retireFlags)
  );

  // Branch condition is not acted on yet
  instructionDecoder u_dec (
    .instr      (decodeInstr),
    .isBios     (isBios),
    .isKernel   (isKernel),
    .id         (decId),
    .regD       (decRegD),
    .regA       (decRegA),
    .regB       (decRegB),
    .offset     (decOffset),
    .branchCond ()
  );

  registerFile u_regs (
    .clk       (clk),
    .reset     (reset),
    .readA     (decRegA),
    .readB     (decRegB),
    .writeEn   (rfWriteEn),
    .writeIdx  (decRegD),
    .writeData (aluResult),
    .dataA     (rfDataA),
    .dataB     (rfDataB)
  );

  shiftAlu u_alu (
    .clk       (clk),
    .reset     (reset),
    .commit    (commit),
    .id        (decId),
    .regD      (decRegD),
    .opA       (rfDataA),
    .opB       (rfDataB),
    .offset    (decOffset),
    .result    (aluResult),
    .writeEn   (aluWriteEn),
    .flags     (),
    .nextFlags (aluNextFlags)
  );

endmodule

// File: logic/executeSequencer.sv
`timescale 1ns/1ns

module executeSequencer (
  input  logic            clk,
  input  logic            reset,
  input  logic            instrReq,
  input  isaPkg::instrT   instr,
  input  logic            retireAck,
  input  isaPkg::instrIdT aluId,
  input  logic            aluWrite,
  input  isaPkg::regIdxT  aluDest,
  input  corePkg::dataT   aluResult,
  input  corePkg::flagsT  aluFlags,
  output logic            instrAck,
  output logic            retireReq,
  output isaPkg::instrT   decodeInstr,
  output logic            commit,
  output isaPkg::instrIdT retireId,
  output logic            retireWrite,
  output isaPkg::regIdxT  retireReg,
  output corePkg::dataT   retireData,
  output corePkg::flagsT  retireFlags
);

  corePkg::seqStateT state;
  isaPkg::instrT instrReg;

  assign decodeInstr = instrReg;
  assign commit = (state == corePkg::execute);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= corePkg::idle;
      instrAck <= 1'b0;
      retireReq <= 1'b0;
    end else begin
      case (state)
        corePkg::idle: begin
          if (instrReq) begin
            instrAck <= 1'b1;
            state <= corePkg::instrAckHigh;
          end
        end
        corePkg::instrAckHigh: begin
          if (!instrReq) begin
            instrAck <= 1'b0;
            state <= corePkg::execute;
          end
        end
        corePkg::execute: begin
          retireReq <= 1'b1;  // Same edge as the commit
          state <= corePkg::retireHigh;
        end
        corePkg::retireHigh: begin
          if (retireAck) begin
            retireReq <= 1'b0;
            state <= corePkg::retireRelease;
          end
        end
        corePkg::retireRelease: begin
          if (!retireAck) begin
            state <= corePkg::idle;
          end
        end
        default: state <= corePkg::idle;
      endcase
    end
  end

  // Captured on acceptance, stable until the next one
  always_ff @(posedge clk) begin
    if (state == corePkg::idle && instrReq) begin
      instrReg <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      retireId <= '0;
      retireWrite <= 1'b0;
      retireReg <= '0;
      retireData <= '0;
      retireFlags <= '0;
    end else if (commit) begin
      retireId <= aluId;
      retireWrite <= aluWrite;
      retireReg <= aluDest;
      retireData <= aluResult;
      retireFlags <= aluFlags;
    end
  end

  ackExclusive: assert property (@(posedge clk) disable iff (reset) !(instrAck && retireReq))
    else $error("instrAck and retireReq high together");

  commitPulse: assert property (@(posedge clk) disable iff (reset)
    commit |=> !commit && retireReq)
    else $error("Commit longer than one cycle or retireReq missing");

endmodule

// File: logic/instructionDecoder.sv
`timescale 1ns/1ns

module instructionDecoder (
  input  isaPkg::instrT      instr,
  input  logic               isBios,
  input  logic               isKernel,
  output isaPkg::instrIdT    id,
  output isaPkg::regIdxT     regD,
  output isaPkg::regIdxT     regA,
  output isaPkg::regIdxT     regB,
  output isaPkg::offsetT     offset,
  output isaPkg::branchCondT branchCond
);

  logic [3:0] opcode;
  logic [1:0] funct1;
  isaPkg::regIdxT fieldLo;   // Bits 2:0
  isaPkg::regIdxT fieldMid;  // Bits 5:3
  isaPkg::regIdxT fieldSrc;  // Bits 8:6
  isaPkg::regIdxT fieldUp;   // Bits 10:8
  isaPkg::offsetT imm3;
  isaPkg::offsetT imm5;
  isaPkg::offsetT imm8;

  assign opcode = instr[15:12];
  assign funct1 = instr[7:6];
  assign fieldLo = isaPkg::regIdxT'(instr[2:0]);
  assign fieldMid = isaPkg::regIdxT'(instr[5:3]);
  assign fieldSrc = isaPkg::regIdxT'(instr[8:6]);
  assign fieldUp = isaPkg::regIdxT'(instr[10:8]);
  assign imm3 = isaPkg::offsetT'(instr[8:6]);
  assign imm5 = isaPkg::offsetT'(instr[10:6]);
  assign imm8 = isaPkg::offsetT'(instr[7:0]);

  always_comb begin
    id = isaPkg::idUndef;
    regD = '0;
    regA = '0;
    regB = '0;
    offset = '0;
    branchCond = isaPkg::condNone;
    case (opcode)
      4'h0: begin // LSL and LSR by immediate
        id = instr[11] ? isaPkg::idLsrImm : isaPkg::idLslImm;
        regD = fieldLo;
        regA = fieldMid;
        offset = imm5;
      end
      4'h1: begin
        regD = fieldLo;
        regA = fieldMid;
        if (!instr[11]) begin
          id = isaPkg::idAsrImm;
          offset = imm5;
        end else begin
          case (instr[10:9])
            2'd0: begin
              id = isaPkg::idAddReg;
              regB = fieldSrc;
            end
            2'd1: begin
              id = isaPkg::idSubReg;
              regB = fieldSrc;
            end
            2'd2: begin
              id = isaPkg::idAddImm3;
              offset = imm3;
            end
            default: begin
              id = isaPkg::idSubImm3;
              offset = imm3;
            end
          endcase
        end
      end
      4'h2, 4'h3: begin // MOV, CMP, ADD, SUB with 8-bit immediate
        regD = fieldUp;
        regA = fieldUp;
        offset = imm8;
        case (instr[12:11])
          2'd0: id = isaPkg::idMovImm;
          2'd1: id = isaPkg::idCmpImm;
          2'd2: id = isaPkg::idAddImm8;
          default: id = isaPkg::idSubImm8;
        endcase
      end
      4'h4: begin
        if (instr[11]) begin // PC-relative load
          id = 7'h27;
          regD = fieldUp;
          regA = isaPkg::regPc;
          regB = fieldUp;
          offset = imm8;
        end else begin
          regD = fieldLo;
          regA = fieldLo;
          regB = fieldMid;
          case (instr[10:8])
            3'd4: begin // Hi register forms with IDs 28 to 30
              case (funct1)
                2'd1: begin
                  id = 7'h1c;
                  regB[3] = 1'b1;
                end
                2'd2: begin
                  id = 7'h1d;
                  regD[3] = 1'b1;
                  regA[3] = 1'b1;
                end
                2'd3: begin
                  id = 7'h1e;
                  regD[3] = 1'b1;
                  regA[3] = 1'b1;
                  regB[3] = 1'b1;
                end
                default: id = 7'h0c;
              endcase
            end
            3'd5: begin // IDs 31 to 33
              case (funct1)
                2'd1: begin
                  id = 7'h1f;
                  regB[3] = 1'b1;
                end
                2'd2, 2'd3: begin
                  id = funct1[0] ? 7'h21 : 7'h20;
                  regD[3] = 1'b1;
                  regA[3] = 1'b1;
                end
                default: id = 7'h0c;
              endcase
            end
            3'd6: begin // IDs 34 to 37
              id = 7'h22 + funct1;
              regB[3] = funct1[0];
              regD[3] = funct1[1];
              regA[3] = funct1[1];
            end
            3'd7: begin // BX
              branchCond = {1'b0, instr[7:4]};
              id = (branchCond == isaPkg::condSpecial) ? isaPkg::idBxNoCond : isaPkg::idBx;
              regA = isaPkg::regPc;
              regB = fieldLo;
            end
            default: id = 7'h0c + {instr[9:8], funct1}; // Register ALU ops with IDs 12 to 27
          endcase
        end
      end
      4'h5: begin // Register offset load and store
        id = 7'h28 + instr[11:9];
        regD = fieldLo;
        regA = fieldMid;
        regB = fieldSrc;
      end
      4'h6, 4'h7, 4'h8: begin // Immediate offset load and store
        regD = fieldLo;
        regA = fieldMid;
        offset = imm5;
        case (opcode)
          4'h6: id = instr[11] ? 7'h31 : 7'h30;
          4'h7: id = instr[11] ? 7'h33 : 7'h32;
          default: id = instr[11] ? 7'h35 : 7'h34;
        endcase
      end
      4'h9: begin
        id = instr[11] ? 7'h37 : 7'h36;
        regD = fieldUp;
        regA = isaPkg::regLr;
        offset = imm8;
      end
      4'ha: begin
        id = instr[11] ? 7'h39 : 7'h38;
        regD = fieldUp;
        regA = instr[11] ? isaPkg::regLr : isaPkg::regPc;
        offset = imm8;
      end
      4'hb: begin // Miscellaneous group with IDs 58 to 71
        case (instr[11:8])
          4'h0: id = 7'h3a;
          4'h2, 4'ha: begin
            id = (instr[11] ? 7'h3f : 7'h3b) + funct1;
            regD = fieldLo;
            regB = fieldMid;
          end
          4'h4, 4'hd: begin
            id = instr[11] ? 7'h44 : 7'h43;
            regD = fieldLo;
          end
          4'he: begin
            case (funct1)
              2'd0, 2'd2: begin // OUTPUT and INPUT
                id = funct1[1] ? 7'h47 : 7'h45;
                regD = fieldLo;
              end
              2'd1: id = 7'h46; // PAUSE
              default: id = isaPkg::idUndefMisc;
            endcase
          end
          default: id = isaPkg::idUndefMisc;
        endcase
      end
      4'hc: begin // SWI enters the OS unless already in kernel
        id = isaPkg::idSwi;
        offset = isKernel ? '0 : isaPkg::osStart;
        regB = isaPkg::regSp;
        branchCond = isaPkg::condAlways;
      end
      4'hd: begin
        id = isaPkg::idBranch;
        branchCond = {1'b0, instr[11:8]};
        offset = imm8;
        regA = isaPkg::regPc;
      end
      4'he: begin
        id = instr[11] ? isaPkg::idHalt : isaPkg::idNop;
        if (id == isaPkg::idHalt && isBios) begin // BIOS halt hands over to the OS
          id = isaPkg::idBiosExit;
          branchCond = isaPkg::condSpecial;
          offset = isaPkg::osStart;
          regA = isaPkg::regPc;
        end
      end
      default: id = (instr == isaPkg::instrResetWord) ? isaPkg::idResetWord : isaPkg::idUndef;
    endcase
  end

endmodule

// File: logic/isaPkg.sv
package isaPkg;

  localparam int instrWidth = 16;
  localparam int idWidth = 7;
  localparam int regIdxWidth = 4;
  localparam int offsetWidth = 12;
  localparam int branchCondWidth = 5;

  typedef logic [instrWidth-1:0] instrT;
  typedef logic [idWidth-1:0] instrIdT;
  typedef logic [regIdxWidth-1:0] regIdxT;
  typedef logic [offsetWidth-1:0] offsetT;
  typedef logic [branchCondWidth-1:0] branchCondT;

  // Executed subset
  localparam instrIdT idLslImm = 7'd1;
  localparam instrIdT idLsrImm = 7'd2;
  localparam instrIdT idAsrImm = 7'd3;
  localparam instrIdT idAddReg = 7'd4;
  localparam instrIdT idSubReg = 7'd5;
  localparam instrIdT idAddImm3 = 7'd6;
  localparam instrIdT idSubImm3 = 7'd7;
  localparam instrIdT idMovImm = 7'd8;
  localparam instrIdT idCmpImm = 7'd9;
  localparam instrIdT idAddImm8 = 7'd10;
  localparam instrIdT idSubImm8 = 7'd11;

  // Decoded but not executed
  localparam instrIdT idBx = 7'd38;
  localparam instrIdT idSwi = 7'd72;
  localparam instrIdT idBranch = 7'd73;
  localparam instrIdT idNop = 7'd74;
  localparam instrIdT idHalt = 7'd75;
  localparam instrIdT idBxNoCond = 7'd76;   // BX with condition field 0xf
  localparam instrIdT idBiosExit = 7'd77;
  localparam instrIdT idResetWord = 7'd100;
  localparam instrIdT idUndefMisc = 7'h7a;  // Unused slots of opcode 0xb
  localparam instrIdT idUndef = 7'h7f;

  localparam instrT instrResetWord = 16'hffff;

  localparam branchCondT condAlways = 5'h0e;
  localparam branchCondT condSpecial = 5'h0f;
  localparam branchCondT condNone = 5'h1f;

  // Special registers
  localparam regIdxT regSp = 4'd13;
  localparam regIdxT regLr = 4'd14;
  localparam regIdxT regPc = 4'd15;

  localparam offsetT osStart = 12'd2048;  // OS entry point

endpackage

// File: logic/registerFile.sv
`timescale 1ns/1ns

module registerFile (
  input  logic           clk,
  input  logic           reset,
  input  isaPkg::regIdxT readA,
  input  isaPkg::regIdxT readB,
  input  logic           writeEn,
  input  isaPkg::regIdxT writeIdx,
  input  corePkg::dataT  writeData,
  output corePkg::dataT  dataA,
  output corePkg::dataT  dataB
);

  corePkg::dataT regs [corePkg::regCount];

  // No bypass, the write lands after the read has been used
  assign dataA = regs[readA];
  assign dataB = regs[readB];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < corePkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeIdx] <= writeData;
    end
  end

endmodule

// File: logic/shiftAlu.sv
`timescale 1ns/1ns

module shiftAlu (
  input  logic            clk,
  input  logic            reset,
  input  logic            commit,
  input  isaPkg::instrIdT id,
  input  isaPkg::regIdxT  regD,
  input  corePkg::dataT   opA,
  input  corePkg::dataT   opB,
  input  isaPkg::offsetT  offset,
  output corePkg::dataT   result,
  output logic            writeEn,
  output corePkg::flagsT  flags,
  output corePkg::flagsT  nextFlags
);

  localparam int msb = corePkg::dataWidth - 1;

  corePkg::dataT immData;
  corePkg::dataT addB;
  corePkg::dataT addOp;
  corePkg::dataT sum;
  logic carry;
  logic isSub;
  logic doArith;
  logic setNz;
  logic [4:0] shamt;

  assign immData = corePkg::dataT'(offset);
  assign shamt = offset[4:0];

  always_comb begin
    addB = opB;
    isSub = 1'b0;
    doArith = 1'b0;
    setNz = 1'b1;
    writeEn = 1'b1;
    result = '0;
    case (id)
      isaPkg::idLslImm: result = opA << shamt;  // 16 and up clears
      isaPkg::idLsrImm: result = opA >> shamt;
      isaPkg::idAsrImm: result = corePkg::dataT'($signed(opA) >>> shamt);  // Sign fill
      isaPkg::idAddReg: doArith = 1'b1;
      isaPkg::idSubReg: begin
        doArith = 1'b1;
        isSub = 1'b1;
      end
      isaPkg::idAddImm3, isaPkg::idAddImm8: begin
        addB = immData;
        doArith = 1'b1;
      end
      isaPkg::idSubImm3, isaPkg::idSubImm8: begin
        addB = immData;
        doArith = 1'b1;
        isSub = 1'b1;
      end
      isaPkg::idMovImm: result = immData;
      isaPkg::idCmpImm: begin
        addB = immData;
        doArith = 1'b1;
        isSub = 1'b1;
        writeEn = 1'b0;  // Flags only
      end
      default: begin
        setNz = 1'b0;
        writeEn = 1'b0;
      end
    endcase
    addOp = isSub ? ~addB : addB;  // Subtract as A + ~B + 1
    {carry, sum} = {1'b0, opA} + {1'b0, addOp} + {{corePkg::dataWidth{1'b0}}, isSub};
    if (doArith) begin
      result = sum;
    end
  end

  always_comb begin
    nextFlags = flags;
    if (setNz) begin
      nextFlags[corePkg::flagN] = result[msb];
      nextFlags[corePkg::flagZ] = (result == '0);
    end
    if (doArith) begin
      nextFlags[corePkg::flagC] = carry;  // No borrow on subtract
      nextFlags[corePkg::flagV] = (opA[msb] == addOp[msb]) && (sum[msb] != opA[msb]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (commit) begin
      flags <= nextFlags;
    end
  end

  // Executed forms only encode r0 to r7 as destination
  lowDest: assert property (@(posedge clk) disable iff (reset)
    commit && writeEn |-> !regD[isaPkg::regIdxWidth-1])
    else $error("Write-back to a high register");

endmodule

// File: testbench/decodeExecuteTb.sv
`timescale 1ns/1ns

module decodeExecuteTb;

  localparam int clkPeriod = 40;
  localparam int arithCount = 48;
  localparam int shiftCount = 32;
  localparam int wordCount = 300;
  localparam int bpCount = 20;
  localparam int totalInstr = 1 + arithCount + 2 * shiftCount + 4 * wordCount + bpCount;

  typedef struct packed {
    logic [6:0]  id;
    logic        write;
    logic [3:0]  dest;
    logic [15:0] data;
    logic [3:0]  flags;
    logic        full;   // Executed, so dest and data are checked
  } recordT;

  logic clk;
  logic reset;
  logic instrReq;
  logic [15:0] instr;
  logic instrAck;
  logic isBios;
  logic isKernel;
  logic retireReq;
  logic [6:0] retireId;
  logic retireWrite;
  logic [3:0] retireReg;
  logic [15:0] retireData;
  logic [3:0] retireFlags;
  logic retireAck;

  logic [31:0] lcgState = 32'hae23bfc9;
  logic [15:0] modelRegs [8];
  logic [3:0] modelFlags;
  recordT expQ [$];
  string nameQ [$];
  int sentCount = 0;
  int retiredCount = 0;
  logic backPressure = 1'b0;

  decodeExecuteTop i_dut (
    .clk         (clk),
    .reset       (reset),
    .instrReq    (instrReq),
    .instr       (instr),
    .instrAck    (instrAck),
    .isBios      (isBios),
    .isKernel    (isKernel),
    .retireReq   (retireReq),
    .retireId    (retireId),
    .retireWrite (retireWrite),
    .retireReg   (retireReg),
    .retireData  (retireData),
    .retireFlags (retireFlags),
    .retireAck   (retireAck)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int randBelow(input int n);
    logic [31:0] r;
    r = nextRandom();
    return int'(r[31:8] % n);  // Upper bits are the better ones
  endfunction

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic checkValue(input string testName, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error %s %s: expected 0x%0h, actual 0x%0h", testName, field, expected, actual);
      $display("test failed");
      $fatal(1, "Stopping at first error");
    end
  endtask

  // Instruction ID by the reference numbering
  function automatic logic [6:0] refDecode(input logic [15:0] w, input logic bios);
    logic [1:0] f;
    f = w[7:6];
    case (w[15:12])
      4'h0: return w[11] ? 7'd2 : 7'd1;
      4'h1: return w[11] ? 7'd4 + w[10:9] : 7'd3;
      4'h2, 4'h3: return 7'd8 + w[12:11];
      4'h4: begin
        if (w[11]) begin
          return 7'd39;  // PC-relative load
        end
        case (w[10:8])
          3'd4: return (f == 2'd0) ? 7'd12 : 7'd27 + f;
          3'd5: return (f == 2'd0) ? 7'd12 : 7'd30 + f;
          3'd6: return 7'd34 + f;
          3'd7: return (w[7:4] == 4'hf) ? 7'd76 : 7'd38;
          default: return 7'd12 + {w[9:8], f};
        endcase
      end
      4'h5: return 7'd40 + w[11:9];
      4'h6: return 7'd48 + w[11];
      4'h7: return 7'd50 + w[11];
      4'h8: return 7'd52 + w[11];
      4'h9: return 7'd54 + w[11];
      4'ha: return 7'd56 + w[11];
      4'hb: begin
        case (w[11:8])
          4'h0: return 7'd58;
          4'h2: return 7'd59 + f;
          4'ha: return 7'd63 + f;
          4'h4: return 7'd67;
          4'hd: return 7'd68;
          4'he: return (f == 2'd3) ? 7'h7a : 7'd69 + f;
          default: return 7'h7a;
        endcase
      end
      4'hc: return 7'd72;
      4'hd: return 7'd73;
      4'he: return !w[11] ? 7'd74 : (bios ? 7'd77 : 7'd75);  // BIOS halt exits to the OS
      default: return (w == 16'hffff) ? 7'd100 : 7'h7f;
    endcase
  endfunction

  // Expected retire record that also advances the model registers and flags
  function automatic recordT predict(input logic [15:0] w, input logic bios);
    recordT e;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic [16:0] wide;
    logic [4:0] sh;
    logic [2:0] rd;
    logic arith;
    logic sub;
    int sr;
    e.id = refDecode(w, bios);
    e.full = (e.id >= 7'd1) && (e.id <= 7'd11);
    e.write = e.full && (e.id != 7'd9);  // CMP only sets flags
    e.flags = modelFlags;
    e.dest = '0;
    e.data = '0;
    if (e.full) begin
      sh = w[10:6];
      if (e.id >= 7'd8) begin
        rd = w[10:8];
        a = modelRegs[rd];
        b = {8'h00, w[7:0]};
      end else begin
        rd = w[2:0];
        a = modelRegs[w[5:3]];
        b = (e.id <= 7'd5) ? modelRegs[w[8:6]] : {13'h0000, w[8:6]};
      end
      arith = (e.id >= 7'd4 && e.id <= 7'd7) || e.id >= 7'd9;
      sub = (e.id == 7'd5) || (e.id == 7'd7) || (e.id == 7'd9) || (e.id == 7'd11);
      case (e.id)
        7'd1: r = (sh >= 5'd16) ? 16'h0000 : a << sh;
        7'd2: r = (sh >= 5'd16) ? 16'h0000 : a >> sh;
        7'd3: r = (sh >= 5'd16) ? {16{a[15]}} : 16'($signed(a) >>> sh);
        7'd8: r = b;
        default: r = sub ? a - b : a + b;
      endcase
      if (arith) begin
        wide = {1'b0, a} + {1'b0, b};
        sr = sub ? $signed(a) - $signed(b) : $signed(a) + $signed(b);
        e.flags[1] = sub ? (a >= b) : wide[16];  // No borrow on subtract
        e.flags[0] = (sr > 32767) || (sr < -32768);
      end
      e.flags[3] = r[15];
      e.flags[2] = (r == 16'h0000);
      e.dest = {1'b0, rd};
      e.data = r;
      if (e.write) begin
        modelRegs[rd] = r;
      end
      modelFlags = e.flags;
    end
    return e;
  endfunction

  function automatic logic [15:0] randomArith();
    logic [2:0] rd;
    logic [2:0] ra;
    logic [2:0] rb;
    logic [7:0] imm;
    rd = 3'(randBelow(8));
    ra = 3'(randBelow(8));
    rb = 3'(randBelow(8));
    imm = 8'(randBelow(256));
    case (randBelow(8))
      0: return {5'b00100, rd, imm};  // MOV
      1: return {5'b00101, rd, imm};  // CMP
      2: return {5'b00110, rd, imm};
      3: return {5'b00111, rd, imm};
      4: return {4'h1, 3'b100, rb, ra, rd};
      5: return {4'h1, 3'b101, rb, ra, rd};
      6: return {4'h1, 3'b110, imm[2:0], ra, rd};
      default: return {4'h1, 3'b111, imm[2:0], ra, rd};
    endcase
  endfunction

  task automatic waitRandom();
    repeat (randBelow(4)) @(posedge clk);
  endtask

  task automatic sendInstr(input logic [15:0] word, input logic bios, input logic kernel,
                           input string name);
    expQ.push_back(predict(word, bios));
    nameQ.push_back(name);
    sentCount++;
    waitRandom();
    isBios <= bios;
    isKernel <= kernel;
    instr <= word;
    instrReq <= 1'b1;
    do @(posedge clk); while (!instrAck);
    waitRandom();
    instrReq <= 1'b0;
    do @(posedge clk); while (instrAck);
  endtask

  task automatic checkStable(input recordT snap);
    checkValue("record stable", "retireId", snap.id, retireId);
    checkValue("record stable", "retireWrite", snap.write, retireWrite);
    checkValue("record stable", "retireReg", snap.dest, retireReg);
    checkValue("record stable", "retireData", snap.data, retireData);
    checkValue("record stable", "retireFlags", snap.flags, retireFlags);
  endtask

  // Retire consumer
  initial begin : responder
    recordT snap;
    int delay;
    forever begin
      @(posedge clk);
      if (!reset && retireReq) begin
        snap = '{id: retireId, write: retireWrite, dest: retireReg, data: retireData,
                 flags: retireFlags, full: 1'b0};
        delay = backPressure ? randBelow(21) : randBelow(4);
        repeat (delay) begin
          @(posedge clk);
          checkStable(snap);
        end
        retireAck <= 1'b1;
        do begin
          @(posedge clk);
          checkStable(snap);
        end while (retireReq);
        delay = backPressure ? randBelow(21) : randBelow(4);
        repeat (delay) begin
          @(posedge clk);
          checkStable(snap);
        end
        retireAck <= 1'b0;
        @(posedge clk);
        checkStable(snap);  // Held until the DUT sees retireAck low
      end
    end
  end

  // Handshake order and retire record comparison
  initial begin : monitor
    logic lastAck;
    logic lastRetReq;
    logic lastRetAck;
    logic retireOpen;
    recordT e;
    string name;
    lastAck = 1'b0;
    lastRetReq = 1'b0;
    lastRetAck = 1'b0;
    retireOpen = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset) begin
        if (instrAck && !lastAck && !instrReq) begin
          reportFailure("instrAck rose without a pending instrReq");
        end
        if (instrAck && !lastAck && retireOpen) begin
          reportFailure("instrAck rose before the retire handshake had completed");
        end
        if (!instrAck && lastAck && instrReq) begin
          reportFailure("instrAck fell while instrReq was still high");
        end
        if (retireReq && !lastRetReq) begin
          if (expQ.size() == 0) begin
            reportFailure("retireReq rose with no instruction outstanding");
          end else begin
            e = expQ.pop_front();
            name = nameQ.pop_front();
            checkValue(name, "retireId", e.id, retireId);
            checkValue(name, "retireWrite", e.write, retireWrite);
            checkValue(name, "retireFlags", e.flags, retireFlags);
            if (e.full) begin
              checkValue(name, "retireReg", e.dest, retireReg);
              checkValue(name, "retireData", e.data, retireData);
            end
            retiredCount++;
            retireOpen = 1'b1;
          end
        end
        if (lastRetAck && !retireAck) begin
          retireOpen = 1'b0;
        end
      end
      lastAck = instrAck;
      lastRetReq = retireReq;
      lastRetAck = retireAck;
    end
  end

  initial begin : watchdog
    #(totalInstr * 400 * clkPeriod);
    $display("Timeout: handshake stalled, %0d of %0d instructions retired",
             retiredCount, sentCount);
    $display("test failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin : main
    logic [15:0] word;
    logic [2:0] ra;
    logic [2:0] rd;
    reset = 1'b1;
    instrReq = 1'b0;
    instr = '0;
    isBios = 1'b0;
    isKernel = 1'b0;
    retireAck = 1'b0;
    modelFlags = '0;
    foreach (modelRegs[i]) begin
      modelRegs[i] = '0;
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    checkValue("reset state", "instrAck", 1'b0, instrAck);
    checkValue("reset state", "retireReq", 1'b0, retireReq);
    checkValue("reset state", "retireId", 7'd0, retireId);
    checkValue("reset state", "retireWrite", 1'b0, retireWrite);
    checkValue("reset state", "retireReg", 4'd0, retireReg);
    checkValue("reset state", "retireData", 16'd0, retireData);
    checkValue("reset state", "retireFlags", 4'd0, retireFlags);
    sendInstr(16'h2800, 1'b0, 1'b0, "reset cmp");  // CMP r0, #0

    for (int i = 0; i < arithCount; i++) begin
      sendInstr(randomArith(), 1'b0, 1'b0, $sformatf("arith %0d", i));
    end

    // Arithmetic first so that C and V carry into the shift
    for (int amt = 0; amt < shiftCount; amt++) begin
      sendInstr(randomArith(), 1'b0, 1'b0, $sformatf("shift setup %0d", amt));
      ra = 3'(randBelow(8));
      rd = 3'(randBelow(8));
      case (randBelow(3))
        0: word = {4'h0, 1'b0, 5'(amt), ra, rd};
        1: word = {4'h0, 1'b1, 5'(amt), ra, rd};
        default: word = {4'h1, 1'b0, 5'(amt), ra, rd};
      endcase
      sendInstr(word, 1'b0, 1'b0, $sformatf("shift %0d", amt));
    end

    for (int i = 0; i < wordCount; i++) begin
      word = (i == 0) ? 16'hffff : 16'(nextRandom() >> 8);
      for (int m = 0; m < 4; m++) begin
        sendInstr(word, m[1], m[0], $sformatf("decode %0d mode %0d", i, m));
      end
    end

    backPressure = 1'b1;
    for (int i = 0; i < bpCount; i++) begin
      sendInstr(randomArith(), 1'b0, 1'b0, $sformatf("back-pressure %0d", i));
    end

    wait (retiredCount == sentCount);
    repeat (2) @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule
